//--- common/sdram_pkg.sv
// ======================================================================
// SDRAM subsystem shared definitions
// Widths, command codes, init timing, pin bundle and FSM encodings
// ======================================================================
`default_nettype none

package sdram_pkg;

    localparam int N_PORTS   = 4;      // Client ports
    localparam int N_BANKS   = 4;
    localparam int ROW_W     = 13;
    localparam int COL_W     = 10;
    localparam int TAG_DEPTH = 4;      // READ to rdy tag queue

    // Bank ring positions, bit 0 is idle
    localparam int RING_W    = 8;
    localparam int READ_BIT  = 2;
    localparam int DQLO_BIT  = 5;      // Low word on dq
    localparam int DQHI_BIT  = 6;      // High word on dq

    // Power-up timing in clock cycles
    localparam int WAIT_W    = 14;
    localparam int INIT_WAIT = 10000;  // About 100 us
    localparam int T_RP      = 2;
    localparam int T_RFC     = 11;
    localparam int T_MRD     = 3;

    // Single write burst, CL2, sequential, BL2
    localparam logic [ROW_W-1:0] MODE_WORD = 13'b000_1_00_010_0_001;

    typedef logic [ROW_W-1:0] row_t;
    typedef logic [COL_W-1:0] col_t;
    typedef logic [1:0]       bank_t;
    typedef logic [15:0]      word_t;
    typedef logic [31:0]      dword_t;
    typedef logic [1:0]       port_t;
    typedef logic [24:0]      req_addr_t;  // Bank, row, column

    // {cs_n, ras_n, cas_n, we_n}
    typedef enum logic [3:0] {
        CMD_LOAD_MODE   = 4'b0000,
        CMD_AUTOREFRESH = 4'b0001,
        CMD_PRECHARGE   = 4'b0010,
        CMD_ACTIVE      = 4'b0011,
        CMD_READ        = 4'b0101,
        CMD_NOP         = 4'b0111,
        CMD_INHIBIT     = 4'b1000
    } sdram_cmd_t;

    typedef struct packed {
        sdram_cmd_t  cmd;
        logic [12:0] a;
        bank_t       ba;
        logic [1:0]  dqm;  // {dqmh, dqml}
    } sdram_pins_t;

    localparam sdram_pins_t PINS_NOP = '{cmd: CMD_NOP, a: '0, ba: '0, dqm: 2'b11};

    typedef enum logic [2:0] {
        WAIT_POWER,
        PRECHARGE_ALL,
        REFRESH_1,
        REFRESH_2,
        LOAD_MODE,
        DONE
    } init_state_t;

    function automatic bank_t addr_bank(req_addr_t addr);
        return addr[24:23];
    endfunction

    function automatic row_t addr_row(req_addr_t addr);
        return addr[22:10];
    endfunction

    // Bursts sit on even columns
    function automatic col_t addr_col(req_addr_t addr);
        return {addr[9:1], 1'b0};
    endfunction

endpackage

`default_nettype wire

//--- sdram/sdram_init.sv
// ======================================================================
// SDRAM power-up sequencer
// Wait, precharge all, two refreshes, mode load, then flags ready
// ======================================================================
`timescale 1ns/1ps
`default_nettype none

module sdram_init import sdram_pkg::*; (
    input  wire         clk,
    input  wire         rst,
    output sdram_pins_t pins,
    output logic        init_done
);

    init_state_t       state;
    logic [WAIT_W-1:0] wait_cnt;
    logic              fire;       // First cycle of a command state

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            state     <= WAIT_POWER;
            wait_cnt  <= WAIT_W'(INIT_WAIT - 1);
            fire      <= 1'b0;
            pins      <= PINS_NOP;
            init_done <= 1'b0;
        end else begin
            pins <= PINS_NOP;  // NOP between commands
            fire <= 1'b0;

            // Command goes out one cycle after state entry
            if (fire) begin
                case (state)
                    PRECHARGE_ALL: begin
                        pins.cmd   <= CMD_PRECHARGE;
                        pins.a[10] <= 1'b1;          // All banks
                    end
                    REFRESH_1, REFRESH_2: pins.cmd <= CMD_AUTOREFRESH;
                    LOAD_MODE: begin
                        pins.cmd <= CMD_LOAD_MODE;
                        pins.a   <= MODE_WORD;
                    end
                    default: pins.cmd <= CMD_NOP;
                endcase
            end

            if (wait_cnt != '0) begin
                wait_cnt <= wait_cnt - 1'b1;
            end else begin
                case (state)
                    WAIT_POWER: begin
                        state    <= PRECHARGE_ALL;
                        wait_cnt <= WAIT_W'(T_RP);
                        fire     <= 1'b1;
                    end
                    PRECHARGE_ALL: begin
                        state    <= REFRESH_1;
                        wait_cnt <= WAIT_W'(T_RFC);
                        fire     <= 1'b1;
                    end
                    REFRESH_1: begin
                        state    <= REFRESH_2;
                        wait_cnt <= WAIT_W'(T_RFC);
                        fire     <= 1'b1;
                    end
                    REFRESH_2: begin
                        state    <= LOAD_MODE;
                        wait_cnt <= WAIT_W'(T_MRD);
                        fire     <= 1'b1;
                    end
                    LOAD_MODE: begin
                        state     <= DONE;
                        init_done <= 1'b1;  // Held from here on
                    end
                    default: state <= DONE;
                endcase
            end
        end
    end

endmodule

`default_nettype wire

//--- sdram/sdram_bank_core.sv
// ======================================================================
// Four-bank SDRAM read scheduler
// Per-bank state rings overlap ACTIVE/READ pairs across banks
// ======================================================================
`timescale 1ns/1ps
`default_nettype none

module sdram_bank_core import sdram_pkg::*; (
    input  wire         clk,
    input  wire         rst,
    input  wire         init_done,
    input  wire         rd,
    input  req_addr_t   addr,
    input  port_t       tag,
    output logic        accept,
    output logic        rdy,
    output port_t       rtag,
    output dword_t      dout,
    output sdram_pins_t pins,
    input  word_t       dq_in
);

    // Request held between ACTIVE and READ
    typedef struct packed {
        col_t  col;
        bank_t ba;
        port_t tag;
    } stage_t;

    logic [RING_W-1:0] ring [N_BANKS];  // One-hot, bit 0 idle
    logic [RING_W-1:0] all_st;          // Union of all banks
    bank_t             rq_ba;
    logic              activate;
    logic              do_read;
    logic              get_low;
    logic              get_high;

    stage_t            st1;             // Loaded on ACTIVE
    stage_t            st0;             // Used by READ
    port_t             tag_q [TAG_DEPTH];
    word_t             lo_q;

    always_comb begin
        all_st = '0;
        for (int b = 0; b < N_BANKS; b++) begin
            all_st = all_st | ring[b];
        end
        rq_ba    = addr_bank(addr);
        do_read  = all_st[READ_BIT];
        get_low  = all_st[DQLO_BIT];
        get_high = all_st[DQHI_BIT];
        // Bank must be idle. A READ due now would collide with ACTIVE on
        // the command bus, one due next cycle would collide on the bursts
        activate = rd && init_done && ring[rq_ba][0]
                   && !all_st[READ_BIT-1] && !all_st[READ_BIT];
    end

    assign accept = activate;

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            for (int b = 0; b < N_BANKS; b++) begin
                ring[b] <= RING_W'(1);
            end
            rdy  <= 1'b0;
            pins <= PINS_NOP;
        end else begin
            // Rings wait at idle for ACTIVE and at READ_BIT for READ
            for (int b = 0; b < N_BANKS; b++) begin
                if ((activate && rq_ba == bank_t'(b)) ||
                    (do_read && st0.ba == bank_t'(b)) ||
                    (!ring[b][0] && !ring[b][READ_BIT])) begin
                    ring[b] <= {ring[b][RING_W-2:0], ring[b][RING_W-1]};
                end
            end

            rdy      <= get_high;  // dout valid next cycle
            pins.cmd <= CMD_NOP;
            pins.dqm <= 2'b00;     // Both bytes

            if (activate) begin
                pins.cmd <= CMD_ACTIVE;
                pins.a   <= addr_row(addr);
                pins.ba  <= rq_ba;
            end
            if (do_read) begin
                pins.cmd <= CMD_READ;
                pins.a   <= {2'b00, 1'b1, st0.col};  // A10 auto-precharge
                pins.ba  <= st0.ba;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (activate) begin
            st1 <= '{col: addr_col(addr), ba: rq_ba, tag: tag};
        end
        st0 <= st1;  // READ comes two cycles after accept

        // Tag leaves the queue in step with rdy
        for (int i = 0; i < TAG_DEPTH - 1; i++) begin
            tag_q[i] <= tag_q[i+1];
        end
        if (do_read) begin
            tag_q[TAG_DEPTH-1] <= st0.tag;
        end
        rtag <= tag_q[0];

        if (get_low) begin
            lo_q <= dq_in;
        end
        if (get_high) begin
            dout <= {dq_in, lo_q};  // High word on top
        end
    end

endmodule

`default_nettype wire

//--- hdl/sdram_client_arb.sv
// ======================================================================
// Round-robin client arbiter
// Four-phase req/ack ports in front of the core's rd/accept strobe
// ======================================================================
`timescale 1ns/1ps
`default_nettype none

module sdram_client_arb import sdram_pkg::*; (
    input  wire                clk,
    input  wire                rst,
    input  wire  [N_PORTS-1:0] req,
    input  req_addr_t          addr [N_PORTS],
    output logic [N_PORTS-1:0] ack,
    output dword_t             data [N_PORTS],
    output logic               rd,
    output req_addr_t          core_addr,
    output port_t              core_tag,
    input  wire                accept,
    input  wire                rdy,
    input  port_t              rtag,
    input  dword_t             dout
);

    port_t              ptr;       // Highest priority port
    logic [N_PORTS-1:0] pend;      // Accepted, result not yet back
    logic [N_PORTS-1:0] eligible;
    port_t              pick;
    logic               found;

    assign eligible = req & ~pend & ~ack;

    // Scan downwards so the port nearest ptr wins
    always_comb begin
        port_t cand;
        pick  = ptr;
        found = 1'b0;
        for (int i = N_PORTS - 1; i >= 0; i--) begin
            cand = ptr + port_t'(i);
            if (eligible[cand]) begin
                pick  = cand;
                found = 1'b1;
            end
        end
    end

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            ptr  <= '0;
            pend <= '0;
            ack  <= '0;
            rd   <= 1'b0;
        end else begin
            if (!rd) begin
                if (found) begin
                    rd  <= 1'b1;
                    ptr <= pick + port_t'(1);  // Rotate past the winner
                end
            end else if (accept) begin
                rd             <= 1'b0;
                pend[core_tag] <= 1'b1;
            end

            // Client dropped req, close the handshake
            for (int k = 0; k < N_PORTS; k++) begin
                if (ack[k] && !req[k]) begin
                    ack[k]  <= 1'b0;
                    pend[k] <= 1'b0;
                end
            end

            if (rdy) begin
                ack[rtag] <= 1'b1;
            end
        end
    end

    // Request and result payload
    always_ff @(posedge clk) begin
        if (!rd && found) begin
            core_addr <= addr[pick];
            core_tag  <= pick;
        end
        if (rdy) begin
            data[rtag] <= dout;  // No back-pressure
        end
    end

endmodule

`default_nettype wire

//--- hdl/sdram_subsys_top.sv
// ======================================================================
// Read-only SDRAM subsystem top
// Arbiter, power-up sequencer and bank core with the pin mux
// ======================================================================
`timescale 1ns/1ps
`default_nettype none

module sdram_subsys_top import sdram_pkg::*; (
    input  wire                clk,
    input  wire                rst,
    input  wire  [N_PORTS-1:0] req,
    input  req_addr_t          addr [N_PORTS],
    output logic [N_PORTS-1:0] ack,
    output dword_t             data [N_PORTS],
    output logic               init_done,
    output sdram_pins_t        pins,
    input  word_t              dq_in       // Read-only, no drive side
);

    sdram_pins_t init_pins;
    sdram_pins_t core_pins;
    logic        rd;
    req_addr_t   core_addr;
    port_t       core_tag;
    logic        accept;
    logic        rdy;
    port_t       rtag;
    dword_t      dout;

    // Sequencer owns the pins until the device is set up
    assign pins = init_done ? core_pins : init_pins;

    sdram_init i_init (
        .clk       (clk),
        .rst       (rst),
        .pins      (init_pins),
        .init_done (init_done)
    );

    sdram_client_arb i_arb (
        .clk       (clk),
        .rst       (rst),
        .req       (req),
        .addr      (addr),
        .ack       (ack),
        .data      (data),
        .rd        (rd),
        .core_addr (core_addr),
        .core_tag  (core_tag),
        .accept    (accept),
        .rdy       (rdy),
        .rtag      (rtag),
        .dout      (dout)
    );

    sdram_bank_core i_core (
        .clk       (clk),
        .rst       (rst),
        .init_done (init_done),
        .rd        (rd),
        .addr      (core_addr),
        .tag       (core_tag),
        .accept    (accept),
        .rdy       (rdy),
        .rtag      (rtag),
        .dout      (dout),
        .pins      (core_pins),
        .dq_in     (dq_in)
    );

endmodule

`default_nettype wire

//--- test/sdram_model.sv
// ======================================================================
// Behavioral SDR SDRAM, CL2 and BL2, fixed data pattern
// Checks power-up order, bank open/close and ACTIVE to READ spacing
// ======================================================================
`timescale 1ns/1ps
`default_nettype none

module sdram_model import sdram_pkg::*; (
    input  wire         clk,
    input  wire         rst,
    input  sdram_pins_t pins,
    output word_t       dq,
    output logic        init_seen,  // Full power-up sequence observed
    output int          faults,
    output int          overlaps    // ACTIVEs while another bank is busy
);

    int          cyc;
    int          init_step;             // Power-up commands seen so far
    logic [3:0]  is_open;               // Row open, READ still to come
    int          act_cyc  [N_BANKS];
    int          free_cyc [N_BANKS];    // Precharge done from this cycle
    logic [3:0]  row_lo   [N_BANKS];    // Only low row bits feed the pattern
    logic        rd1_v;                 // Low word goes out next
    logic        rd2_v;                 // High word goes out next
    word_t       rd1_lo;
    word_t       rd1_hi;
    word_t       rd2_hi;

    // Contents: bank on top, row bits next, column below
    function automatic word_t stored_word(bank_t b, logic [3:0] r, col_t c);
        return {b, r, c};
    endfunction

    always @(posedge clk or posedge rst) begin
        int    n_new;
        logic  busy;
        bank_t b;
        n_new = 0;
        busy  = 1'b0;
        b     = pins.ba;
        if (rst) begin
            cyc       <= 0;
            init_step <= 0;
            is_open   <= '0;
            rd1_v     <= 1'b0;
            rd2_v     <= 1'b0;
            dq        <= '0;
            init_seen <= 1'b0;
            faults    <= 0;
            overlaps  <= 0;
            for (int i = 0; i < N_BANKS; i++) begin
                act_cyc[i]  <= 0;
                free_cyc[i] <= 0;
            end
        end else begin
            cyc    <= cyc + 1;
            rd1_v  <= 1'b0;
            rd2_v  <= rd1_v;
            rd2_hi <= rd1_hi;
            dq     <= 'x;                   // Bus idle
            if (rd1_v) dq <= rd1_lo;        // CL2 after READ
            if (rd2_v) dq <= rd2_hi;

            for (int j = 0; j < N_BANKS; j++) begin
                if (bank_t'(j) != b && (is_open[j] || cyc < free_cyc[j])) begin
                    busy = 1'b1;
                end
            end

            case (pins.cmd)
                CMD_PRECHARGE: begin
                    assert (init_step == 0 && pins.a[10]) else begin
                        $display("Protocol fault at %0t: PRECHARGE out of order or without A10",
                                 $time);
                        n_new++;
                    end
                    init_step <= 1;
                end
                CMD_AUTOREFRESH: begin
                    assert (init_step == 1 || init_step == 2) else begin
                        $display("Protocol fault at %0t: AUTOREFRESH out of order", $time);
                        n_new++;
                    end
                    init_step <= init_step + 1;
                end
                CMD_LOAD_MODE: begin
                    assert (init_step == 3 && pins.a == MODE_WORD) else begin
                        $display("Protocol fault at %0t: LOAD_MODE out of order or bad mode %h",
                                 $time, pins.a);
                        n_new++;
                    end
                    init_step <= 4;
                    init_seen <= (init_step == 3) && (pins.a == MODE_WORD);
                end
                CMD_ACTIVE: begin
                    assert (init_step == 4) else begin
                        $display("Protocol fault at %0t: ACTIVE before power-up finished", $time);
                        n_new++;
                    end
                    assert (!is_open[b] && cyc >= free_cyc[b]) else begin
                        $display("Protocol fault at %0t: ACTIVE to bank %0d which is still open",
                                 $time, b);
                        n_new++;
                    end
                    if (busy) overlaps <= overlaps + 1;
                    is_open[b] <= 1'b1;
                    act_cyc[b] <= cyc;
                    row_lo[b]  <= pins.a[3:0];
                end
                CMD_READ: begin
                    assert (is_open[b]) else begin
                        $display("Protocol fault at %0t: READ to bank %0d with no open row",
                                 $time, b);
                        n_new++;
                    end
                    assert (cyc - act_cyc[b] >= 2) else begin
                        $display("Protocol fault at %0t: READ less than two cycles after ACTIVE",
                                 $time);
                        n_new++;
                    end
                    assert (pins.a[10]) else begin
                        $display("Protocol fault at %0t: READ without auto-precharge", $time);
                        n_new++;
                    end
                    is_open[b]  <= 1'b0;
                    free_cyc[b] <= cyc + 2 + T_RP;  // Burst, then tRP
                    rd1_v       <= 1'b1;
                    rd1_lo      <= stored_word(b, row_lo[b], pins.a[9:0]);
                    rd1_hi      <= stored_word(b, row_lo[b], pins.a[9:0] ^ 10'd1);
                end
                CMD_NOP, CMD_INHIBIT: ;
                default: begin
                    $display("Protocol fault at %0t: unknown command %b", $time, pins.cmd);
                    n_new++;
                end
            endcase
            faults <= faults + n_new;
        end
    end

endmodule

`default_nettype wire

//--- test/tb_sdram_subsys.sv
// ======================================================================
// Testbench for the read-only SDRAM subsystem
// Client drivers, SDRAM model, reference data check and report
// ======================================================================
`timescale 1ns/1ps
`default_nettype none

module tb_sdram_subsys import sdram_pkg::*; ();

    localparam int ACK_LIMIT  = 400;               // Cycles per handshake phase
    localparam int BOOT_LIMIT = INIT_WAIT + 500;
    localparam int N_RANDOM   = 200;

    logic               clk = 1'b0;
    logic               rst;
    logic [N_PORTS-1:0] req;
    req_addr_t          addr [N_PORTS];
    logic [N_PORTS-1:0] ack;
    dword_t             data [N_PORTS];
    logic               init_done;
    sdram_pins_t        pins;
    word_t              dq;
    logic               init_seen;
    int                 model_faults;
    int                 overlaps;

    dword_t             exp_q [N_PORTS][$];        // Expected results per port
    logic [N_PORTS-1:0] ack_prev = '0;
    logic [N_PORTS-1:0] req_prev = '0;
    int                 seq_errors = 0;            // Stimulus side
    int                 cmp_errors = 0;            // Data mismatches
    int                 hs_errors = 0;             // Four-phase faults
    int                 n_checked = 0;
    int                 tests_run = 0;
    int                 tests_failed = 0;
    int                 err_mark = 0;

    always #4 clk = ~clk;  // 8 ns

    sdram_subsys_top i_sdram_subsys_top (
        .clk       (clk),
        .rst       (rst),
        .req       (req),
        .addr      (addr),
        .ack       (ack),
        .data      (data),
        .init_done (init_done),
        .pins      (pins),
        .dq_in     (dq)
    );

    sdram_model i_sdram_model (
        .clk       (clk),
        .rst       (rst),
        .pins      (pins),
        .dq        (dq),
        .init_seen (init_seen),
        .faults    (model_faults),
        .overlaps  (overlaps)
    );

    // Even column word in the low half, odd column word in the high half
    function automatic dword_t expected_dword(input req_addr_t a);
        logic [1:0] b;
        logic [3:0] r;
        logic [9:0] c0;
        b  = a[24:23];
        r  = a[13:10];           // Low row bits
        c0 = {a[9:1], 1'b0};
        return {b, r, c0 | 10'd1, b, r, c0};
    endfunction

    function automatic req_addr_t make_addr(input bank_t b, input row_t r, input col_t c);
        return {b, r, c};
    endfunction

    function automatic int total_errors();
        return seq_errors + cmp_errors + hs_errors + model_faults;
    endfunction

    task automatic end_test(input string name);
        int n;
        n = total_errors() - err_mark;
        tests_run++;
        if (n == 0) begin
            $display("Test %0d %s: ok", tests_run, name);
        end else begin
            tests_failed++;
            $display("Test %0d %s: failed with %0d errors", tests_run, name, n);
        end
        err_mark = total_errors();
    endtask

    // Raises req with a stable address and queues the expected result
    task automatic start_read(input int k, input req_addr_t a);
        @(negedge clk);
        addr[k] = a;
        req[k]  = 1'b1;
        exp_q[k].push_back(expected_dword(a));
    endtask

    // Hold keeps req up for extra cycles after ack
    task automatic finish_read(input int k, input int hold);
        int n;
        n = 0;
        while (!ack[k] && n < ACK_LIMIT) begin
            @(negedge clk);
            n++;
        end
        assert (ack[k]) else begin
            $display("Timeout: port %0d got no ack within %0d cycles", k, ACK_LIMIT);
            seq_errors++;
        end
        repeat (hold) begin
            @(negedge clk);
            assert (ack[k]) else begin
                $display("Port %0d dropped ack at %0t while req was still high", k, $time);
                seq_errors++;
            end
        end
        req[k] = 1'b0;
        n = 0;
        while (ack[k] && n < ACK_LIMIT) begin
            @(negedge clk);
            n++;
        end
        assert (!ack[k]) else begin
            $display("Timeout: ack on port %0d stayed high after req fell", k);
            seq_errors++;
        end
    endtask

    task automatic read_port(input int k, input req_addr_t a, input int hold);
        start_read(k, a);
        finish_read(k, hold);
    endtask

    task automatic random_reads(input int k, input int count);
        for (int i = 0; i < count; i++) begin
            repeat ($urandom_range(0, 7)) @(negedge clk);
            read_port(k, req_addr_t'($urandom()), 0);
        end
    endtask

    // Compares each rising ack and watches the handshake
    always @(posedge clk) begin
        dword_t want;
        for (int k = 0; k < N_PORTS; k++) begin
            if (ack[k] && !ack_prev[k]) begin
                assert (req_prev[k] && init_done) else begin
                    $display("Handshake fault at %0t: ack[%0d] rose without an open request",
                             $time, k);
                    hs_errors++;
                end
                assert (exp_q[k].size() != 0) else begin
                    $display("Port %0d was acknowledged at %0t with no read outstanding",
                             k, $time);
                    cmp_errors++;
                end
                if (exp_q[k].size() != 0) begin
                    want = exp_q[k].pop_front();
                    n_checked++;
                    assert (data[k] == want) else begin
                        $display("[ERROR] %0t port %0d returned %h, expected %h",
                                 $time, k, data[k], want);
                        cmp_errors++;
                    end
                end
            end
            if (ack_prev[k] && !ack[k]) begin
                assert (!req_prev[k]) else begin
                    $display("Handshake fault at %0t: ack[%0d] fell while req was high",
                             $time, k);
                    hs_errors++;
                end
            end
        end
        ack_prev <= ack;
        req_prev <= req;
    end

    initial begin
        int pick;
        int per_port [N_PORTS];
        int ovl_mark;
        int flt_mark;
        int n;
        pick = $urandom(32'h9785_4bdf);  // Seeds the generator
        rst  = 1'b1;
        req  = '0;
        for (int k = 0; k < N_PORTS; k++) begin
            addr[k]     = '0;
            per_port[k] = 0;
        end
        repeat (2) @(posedge clk);
        @(negedge clk);
        rst = 1'b0;

        // Power-up with a read already waiting
        start_read(0, make_addr(2'd3, 13'h0c5a, 10'h155));
        n = 0;
        while (!init_done && n < BOOT_LIMIT) begin
            @(negedge clk);
            assert (ack == '0) else begin
                $display("Acknowledge seen at %0t before init finished", $time);
                seq_errors++;
            end
            n++;
        end
        assert (init_done) else begin
            $display("Timeout: init_done did not rise within %0d cycles", BOOT_LIMIT);
            seq_errors++;
        end
        assert (init_seen) else begin
            $display("The model did not see the full power-up sequence before init_done");
            seq_errors++;
        end
        finish_read(0, 0);
        end_test("power-up sequence");

        read_port(0, make_addr(2'd1, 13'h1234, 10'h2a6), 0);
        end_test("single read");

        ovl_mark = overlaps;
        fork
            read_port(0, make_addr(2'd0, 13'h0011, 10'h013), 0);
            read_port(1, make_addr(2'd1, 13'h1f22, 10'h104), 0);
            read_port(2, make_addr(2'd2, 13'h0a33, 10'h2f9), 0);
            read_port(3, make_addr(2'd3, 13'h0544, 10'h3fe), 0);
        join
        assert (overlaps > ovl_mark) else begin
            $display("The model saw no overlapping ACTIVE/READ pairs across banks");
            seq_errors++;
        end
        end_test("four banks at once");

        flt_mark = model_faults;
        fork
            read_port(1, make_addr(2'd2, 13'h0101, 10'h020), 0);
            read_port(2, make_addr(2'd2, 13'h0bcd, 10'h021), 0);
        join
        assert (model_faults == flt_mark) else begin
            $display("The model reported a fault during back-to-back same-bank reads");
            seq_errors++;
        end
        end_test("same bank back to back");

        for (int i = 0; i < N_RANDOM; i++) begin
            pick = $urandom_range(0, N_PORTS - 1);
            per_port[pick]++;
        end
        fork
            random_reads(0, per_port[0]);
            random_reads(1, per_port[1]);
            random_reads(2, per_port[2]);
            random_reads(3, per_port[3]);
        join
        end_test("random reads");

        read_port(3, make_addr(2'd0, 13'h0777, 10'h3fe), 6);  // Long req hold
        assert (hs_errors == 0) else begin
            $display("The four-phase handshake was broken %0d times", hs_errors);
            seq_errors++;
        end
        end_test("four-phase handshake");

        for (int k = 0; k < N_PORTS; k++) begin
            assert (exp_q[k].size() == 0) else begin
                $display("Port %0d still has %0d reads without a result", k, exp_q[k].size());
                seq_errors++;
            end
        end

        $display("Tests run: %0d, failed: %0d, data checks: %0d, errors: %0d",
                 tests_run, tests_failed, n_checked, total_errors());
        if (tests_failed == 0 && total_errors() == 0) begin
            $display("STATUS: PASS");
        end else begin
            $display("STATUS: FAIL");
        end
        $finish;
    end

endmodule

`default_nettype wire

//--- vlog.f
common/sdram_pkg.sv
sdram/sdram_init.sv
sdram/sdram_bank_core.sv
hdl/sdram_client_arb.sv
hdl/sdram_subsys_top.sv
test/sdram_model.sv
test/tb_sdram_subsys.sv

//--- run.sh
#!/bin/sh
# Build the testbench with Verilator, run it, then scan the log for failure

cd "$(dirname "$0")" &&
rm -rf obj_dir sim.log &&
verilator --binary --timing --assert -j 0 \
    --top-module tb_sdram_subsys \
    -f vlog.f \
    -o sim_tb &&
./obj_dir/sim_tb | tee sim.log &&
test -s sim.log &&
! grep -q "STATUS: FAIL" sim.log || {
    echo "Simulation run failed"
    exit 1
}
echo "Simulation run finished"
